//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mandel_core
FILELIST = compile.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no pass line in log"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

//--- compile.f
rtl/mandel_fp_pkg.sv
rtl/mandel_view_pkg.sv
rtl/pixel_job_if.sv
rtl/nav_fsm.sv
rtl/pixel_scan.sv
rtl/escape_iter.sv
rtl/frame_store.sv
rtl/mandel_core.sv
dv/tb_mandel_core.sv

//--- dv/tb_mandel_core.sv
// table-driven testbench for mandel_core, inputs driven and outputs sampled on the falling edge
// expected frames come from a fixed-point escape model in this file
`timescale 1ns/1ps

module tb_mandel_core;
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;

    localparam real FP_SCALE = 2.0 ** FP_FRAC;
    // 12 worst-case renders plus room for read-back and the table itself
    localparam int TIMEOUT_CYCLES = 12 * FB_PIXELS * (ITER_MAX + 2) + 20000;

    typedef enum logic [1:0] {K_MODE, K_UP, K_DN} strobe_t;

    typedef struct packed {
        strobe_t   kind;    // which strobe to pulse
        nav_mode_t mode;    // expected mode afterwards
        fp_t       x;       // expected view
        fp_t       y;
        fp_t       step;
        logic      render;  // a frame should follow
        logic      poke;    // also strobe while that frame runs
    } row_t;

    logic        clk_sys;
    logic        rst_sys;
    logic        sig_mode;
    logic        sig_up;
    logic        sig_dn;
    fb_addr_t    rd_addr;
    logic [1:0]  mode;
    logic        busy;
    logic [FP_WIDTH-1:0] view_x;
    logic [FP_WIDTH-1:0] view_y;
    logic [FP_WIDTH-1:0] view_step;
    logic [CIDX_W-1:0]   rd_cidx;

    row_t table_q[$];
    int   errors;
    int   checks;
    int   cycles;

    mandel_core DUT (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .sig_mode  (sig_mode),
        .sig_up    (sig_up),
        .sig_dn    (sig_dn),
        .rd_addr   (rd_addr),
        .mode      (mode),
        .busy      (busy),
        .view_x    (view_x),
        .view_y    (view_y),
        .view_step (view_step),
        .rd_cidx   (rd_cidx)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;  // 8 ns period
    end

    function automatic fp_t to_fp(real r);
        return fp_t'($rtoi(r * FP_SCALE));  // table values are exact in this format
    endfunction

    function automatic real to_real(fp_t v);
        return $itor(v) / FP_SCALE;
    endfunction

    // escape-time model, z starts at 0, products floor-shifted and wrapped to fp_t
    function automatic cidx_t escape_ref(fp_t cr, fp_t ci);
        fp_t    zr;
        fp_t    zi;
        fp_t    zr2;
        fp_t    zi2;
        fp_t    zri;
        longint mag;
        int     k;
        zr = '0;
        zi = '0;
        for (k = 0; k <= ITER_MAX; k++) begin
            zr2 = fp_t'((longint'(zr) * longint'(zr)) >>> FP_FRAC);
            zi2 = fp_t'((longint'(zi) * longint'(zi)) >>> FP_FRAC);
            zri = fp_t'((longint'(zr) * longint'(zi)) >>> FP_FRAC);
            mag = longint'(zr2) + longint'(zi2);  // no wrap on the sum
            if (mag > longint'(to_fp(4.0))) return cidx_t'(k);
            if (k == ITER_MAX) return '0;  // inside
            zr = zr2 - zi2 + cr;
            zi = (zri <<< 1) + ci;
        end
        return '0;
    endfunction

    task automatic check_mode(nav_mode_t got, nav_mode_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns: mode is %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic check_fp(string what, fp_t got, fp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns: %s is %f, expected %f", $time, what,
                     to_real(got), to_real(exp));
        end
    endtask

    task automatic check_cidx(fb_addr_t addr, cidx_t got, cidx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns: pixel %0d holds %0d, expected %0d", $time, addr, got, exp);
        end
    endtask

    // read every pixel back and compare with the model, c built by repeated adds
    task automatic check_frame(fp_t x0, fp_t y0, fp_t stp);
        fp_t      cr;
        fp_t      ci;
        cidx_t    exp;
        fb_addr_t addr;
        int       r;
        int       c;
        ci = y0;
        for (r = 0; r < FB_H; r++) begin
            cr = x0;
            for (c = 0; c < FB_W; c++) begin
                exp  = escape_ref(cr, ci);
                addr = fb_addr_t'(r * FB_W + c);
                @(negedge clk_sys);
                rd_addr = addr;
                @(negedge clk_sys);  // registered read
                check_cidx(addr, rd_cidx, exp);
                cr = cr + stp;
            end
            ci = ci + stp;
        end
    endtask

    task automatic add_row(strobe_t kind, nav_mode_t m, real x, real y, real s,
                           logic render, logic poke);
        row_t r;
        r.kind   = kind;
        r.mode   = m;
        r.x      = to_fp(x);
        r.y      = to_fp(y);
        r.step   = to_fp(s);
        r.render = render;
        r.poke   = poke;
        table_q.push_back(r);
    endtask

    task automatic apply_row(int idx);
        row_t r;
        int   errs_before;
        logic saw_busy;
        r = table_q[idx];
        errs_before = errors;
        @(negedge clk_sys);
        case (r.kind)
            K_MODE:  sig_mode = 1'b1;
            K_UP:    sig_up = 1'b1;
            default: sig_dn = 1'b1;
        endcase
        @(negedge clk_sys);
        sig_mode = 1'b0;
        sig_up   = 1'b0;
        sig_dn   = 1'b0;
        repeat (4) @(negedge clk_sys);  // commit, start, busy
        saw_busy = busy;
        if (saw_busy !== r.render) begin
            errors++;
            if (r.render) $display("row %0d: no render started after the strobe", idx);
            else $display("row %0d: a render started that should not have", idx);
        end
        if (r.poke && saw_busy) begin
            @(negedge clk_sys);
            sig_mode = 1'b1;  // both should be dropped
            sig_dn   = 1'b1;
            @(negedge clk_sys);
            sig_mode = 1'b0;
            sig_dn   = 1'b0;
        end
        while (busy) @(negedge clk_sys);
        if (r.poke) begin
            repeat (4) @(negedge clk_sys);
            if (busy) begin
                errors++;
                $display("row %0d: strobe during a render started another render", idx);
            end
        end
        check_mode(nav_mode_t'(mode), r.mode);
        check_fp("view_x", view_x, r.x);
        check_fp("view_y", view_y, r.y);
        check_fp("view_step", view_step, r.step);
        if (r.render) check_frame(r.x, r.y, r.step);
        $display("row %0d %s: %s", idx, r.kind.name(), (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int i;
        int wait_cnt;
        rst_sys  = 1'b1;
        sig_mode = 1'b0;
        sig_up   = 1'b0;
        sig_dn   = 1'b0;
        rd_addr  = '0;
        errors   = 0;
        checks   = 0;

        // pan of 4 steps is 1.0 at step 0.25
        add_row(K_UP,   MODE_HORIZONTAL, -3.5, -1.0, 0.25,  1'b1, 1'b0);
        add_row(K_DN,   MODE_HORIZONTAL, -2.5, -1.0, 0.25,  1'b1, 1'b0);
        add_row(K_MODE, MODE_VERTICAL,   -2.5, -1.0, 0.25,  1'b0, 1'b0);
        add_row(K_DN,   MODE_VERTICAL,   -2.5,  0.0, 0.25,  1'b1, 1'b0);
        add_row(K_UP,   MODE_VERTICAL,   -2.5, -1.0, 0.25,  1'b1, 1'b0);
        add_row(K_MODE, MODE_ZOOM,       -2.5, -1.0, 0.25,  1'b0, 1'b0);
        add_row(K_DN,   MODE_ZOOM,       -1.5, -0.5, 0.125, 1'b1, 1'b0);  // x+4s, y+2s
        add_row(K_UP,   MODE_ZOOM,       -2.5, -1.0, 0.25,  1'b1, 1'b0);  // x-8s, y-4s
        add_row(K_UP,   MODE_ZOOM,       -2.5, -1.0, 0.25,  1'b0, 1'b0);  // 0.5 over limit
        add_row(K_MODE, MODE_HORIZONTAL, -2.5, -1.0, 0.25,  1'b0, 1'b0);
        add_row(K_UP,   MODE_HORIZONTAL, -3.5, -1.0, 0.25,  1'b1, 1'b1);
        add_row(K_DN,   MODE_HORIZONTAL, -2.5, -1.0, 0.25,  1'b1, 1'b0);

        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_sys = 1'b0;

        // first frame comes without any strobe
        wait_cnt = 0;
        while (!busy && wait_cnt < 8) begin
            @(negedge clk_sys);
            wait_cnt++;
        end
        if (!busy) begin
            errors++;
            $display("reset: no render started after reset");
        end
        check_mode(nav_mode_t'(mode), MODE_HORIZONTAL);
        check_fp("view_x", view_x, to_fp(-2.5));
        check_fp("view_y", view_y, to_fp(-1.0));
        check_fp("view_step", view_step, to_fp(0.25));
        while (busy) @(negedge clk_sys);
        check_frame(to_fp(-2.5), to_fp(-1.0), to_fp(0.25));
        $display("reset frame: %s", (errors == 0) ? "ok" : "mismatch");

        for (i = 0; i < table_q.size(); i++) apply_row(i);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) $display("Result: PASSED");
        else $display("Result: FAILED");
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- rtl/escape_iter.sv
// one pixel at a time
// done comes n+1 cycles after req for n updates and at most ITER_MAX+1 after it
// products wrap at FP_WIDTH and only the |z|^2 sum has a guard bit
`timescale 1ns/1ps

module escape_iter (
    input  logic         clk_sys,
    input  logic         rst_sys,
    pixel_job_if.engine  job
);
    import mandel_fp_pkg::*;

    localparam int PROD_W = 2 * FP_WIDTH;

    fp_t                      zr;       // iterate
    fp_t                      zi;
    cidx_t                    k;        // updates done so far
    logic                     running;
    logic signed [PROD_W-1:0] zr2_full;
    logic signed [PROD_W-1:0] zi2_full;
    logic signed [PROD_W-1:0] zri_full;
    fp_t                      zr2;
    fp_t                      zi2;
    fp_t                      zri;
    logic signed [FP_WIDTH:0] mag;      // |z|^2 with one guard bit
    logic                     escaped;

    // full signed products floor-shifted back to the fp grid
    assign zr2_full = zr * zr;
    assign zi2_full = zi * zi;
    assign zri_full = zr * zi;
    assign zr2 = fp_t'(zr2_full >>> FP_FRAC);
    assign zi2 = fp_t'(zi2_full >>> FP_FRAC);
    assign zri = fp_t'(zri_full >>> FP_FRAC);

    assign mag     = {zr2[FP_WIDTH-1], zr2} + {zi2[FP_WIDTH-1], zi2};
    assign escaped = mag > FP_FOUR;

    always_ff @(posedge clk_sys) begin
        job.done <= 1'b0;
        if (rst_sys) begin
            running <= 1'b0;
            k       <= '0;
        end else if (job.req) begin
            // z = 0 never escapes, so the first update (z = c) happens here
            zr      <= job.c_re;
            zi      <= job.c_im;
            k       <= cidx_t'(1);
            running <= 1'b1;
        end else if (running) begin
            if (escaped) begin
                job.done <= 1'b1;
                job.cidx <= k;
                running  <= 1'b0;
            end else if (k == cidx_t'(ITER_MAX)) begin
                job.done <= 1'b1;
                job.cidx <= '0;  // inside the set
                running  <= 1'b0;
            end else begin
                zr <= zr2 - zi2 + job.c_re;
                zi <= (zri <<< 1) + job.c_im;  // 2*zr*zi doubled after the shift
                k  <= k + 1'b1;
            end
        end
    end

    // a second req would drop the open job without its done
    a_req_idle: assert property (@(posedge clk_sys) disable iff (rst_sys)
        job.req |-> !running)
        else $error("escape_iter: req while a job is open");

endmodule

//--- rtl/frame_store.sv
// read data one cycle after rd_addr, old data on a same-address collision
// contents are undefined until the first frame is written
`timescale 1ns/1ps

module frame_store (
    input  logic                      clk_sys,
    input  logic                      we,
    input  mandel_view_pkg::fb_addr_t wr_addr,
    input  mandel_fp_pkg::cidx_t      wr_cidx,
    input  mandel_view_pkg::fb_addr_t rd_addr,
    output mandel_fp_pkg::cidx_t      rd_cidx
);
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;

    cidx_t mem [FB_PIXELS];  // one index per pixel

    always_ff @(posedge clk_sys) begin
        if (we) mem[wr_addr] <= wr_cidx;
        rd_cidx <= mem[rd_addr];  // registered read
    end

    // the address space is wider than the frame when FB_PIXELS is not a power of two
    a_wr_range: assert property (@(posedge clk_sys) we |-> int'(wr_addr) < FB_PIXELS)
        else $error("frame_store: write outside the frame");

endmodule

//--- rtl/mandel_core.sv
// single clock domain, strobes must arrive debounced and one cycle long
// a render starts by itself within 3 cycles of reset release
`timescale 1ns/1ps

module mandel_core (
    input  logic                                 clk_sys,
    input  logic                                 rst_sys,
    input  logic                                 sig_mode,
    input  logic                                 sig_up,
    input  logic                                 sig_dn,
    input  logic [mandel_view_pkg::FB_ADDR_W-1:0] rd_addr,
    output logic [1:0]                           mode,       // nav_mode_t encoding
    output logic                                 busy,
    output logic [mandel_fp_pkg::FP_WIDTH-1:0]   view_x,
    output logic [mandel_fp_pkg::FP_WIDTH-1:0]   view_y,
    output logic [mandel_fp_pkg::FP_WIDTH-1:0]   view_step,
    output logic [mandel_fp_pkg::CIDX_W-1:0]     rd_cidx
);
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;

    logic     start;    // nav to scanner
    logic     we;       // scanner to frame store
    fb_addr_t wr_addr;
    cidx_t    wr_cidx;

    pixel_job_if job ();  // scanner <-> engine

    nav_fsm u_nav (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .sig_mode (sig_mode),
        .sig_up   (sig_up),
        .sig_dn   (sig_dn),
        .busy     (busy),
        .start    (start),
        .mode     (mode),
        .x_start  (view_x),
        .y_start  (view_y),
        .step     (view_step)
    );

    pixel_scan u_scan (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .start   (start),
        .x_start (view_x),
        .y_start (view_y),
        .step    (view_step),
        .busy    (busy),
        .job     (job.scan),
        .we      (we),
        .wr_addr (wr_addr),
        .wr_cidx (wr_cidx)
    );

    escape_iter u_iter (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .job     (job.engine)
    );

    frame_store u_fb (
        .clk_sys (clk_sys),
        .we      (we),
        .wr_addr (wr_addr),
        .wr_cidx (wr_cidx),
        .rd_addr (rd_addr),
        .rd_cidx (rd_cidx)
    );

endmodule

//--- rtl/mandel_fp_pkg.sv
// signed fixed point, 4 integer bits incl. sign, so values run from -8 to just under 8
// no saturation anywhere, an overflowing result wraps
package mandel_fp_pkg;

    localparam int FP_WIDTH = 25;   // total bits
    localparam int FP_FRAC  = 21;   // fraction bits

    // one coordinate or iterate word
    typedef logic signed [FP_WIDTH-1:0] fp_t;

    // escape bound on |z|^2
    localparam fp_t FP_FOUR = fp_t'(4 <<< FP_FRAC);

    // last index before a point counts as inside
    localparam int ITER_MAX = 63;

    localparam int CIDX_W = 8;      // must hold ITER_MAX
    typedef logic [CIDX_W-1:0] cidx_t;

endpackage

//--- rtl/mandel_view_pkg.sv
// geometry and view constants for a small 16x8 frame
// FB_W and FB_H need not be powers of two, addresses are row * FB_W + col
package mandel_view_pkg;

    localparam int FB_W      = 16;
    localparam int FB_H      = 8;
    localparam int FB_PIXELS = FB_W * FB_H;
    localparam int FB_ADDR_W = $clog2(FB_PIXELS);

    typedef logic [FB_ADDR_W-1:0] fb_addr_t;

    // view after reset, in mandel_fp_pkg format
    localparam mandel_fp_pkg::fp_t X_START =
        mandel_fp_pkg::fp_t'(-(5 <<< (mandel_fp_pkg::FP_FRAC - 1)));  // -2.5
    localparam mandel_fp_pkg::fp_t Y_START =
        mandel_fp_pkg::fp_t'(-(1 <<< mandel_fp_pkg::FP_FRAC));        // -1.0
    localparam mandel_fp_pkg::fp_t STEP_MAX =
        mandel_fp_pkg::fp_t'(1 <<< (mandel_fp_pkg::FP_FRAC - 2));     // 0.25, also reset step

    localparam int PAN_SHIFT = 2;  // pan of 4 pixels

    // what the up and down strobes act on
    typedef enum logic [1:0] {
        MODE_HORIZONTAL = 2'd0,
        MODE_VERTICAL   = 2'd1,
        MODE_ZOOM       = 2'd2
    } nav_mode_t;

endpackage

//--- rtl/nav_fsm.sv
// strobes must be clean single-cycle pulses in clk_sys
// strobes are dropped while a render runs or a change waits for its check
`timescale 1ns/1ps

module nav_fsm (
    input  logic                       clk_sys,
    input  logic                       rst_sys,
    input  logic                       sig_mode,  // next mode
    input  logic                       sig_up,
    input  logic                       sig_dn,
    input  logic                       busy,      // render in progress
    output logic                       start,     // one render per pulse
    output mandel_view_pkg::nav_mode_t mode,
    output mandel_fp_pkg::fp_t         x_start,   // left edge
    output mandel_fp_pkg::fp_t         y_start,   // top edge
    output mandel_fp_pkg::fp_t         step       // pixel pitch
);
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;

    fp_t  x_pend;      // proposed view
    fp_t  y_pend;
    fp_t  step_pend;
    logic changed;     // proposal waiting for its check
    logic render_req;  // frame owed to the scanner
    logic accept;
    fp_t  pan;

    assign accept = !busy && !changed;
    assign pan    = step <<< PAN_SHIFT;  // 4 pixels

    always_ff @(posedge clk_sys) begin
        start <= 1'b0;  // pulse only
        if (rst_sys) begin
            mode       <= MODE_HORIZONTAL;
            x_start    <= X_START;
            y_start    <= Y_START;
            step       <= STEP_MAX;
            changed    <= 1'b0;
            render_req <= 1'b1;  // first frame after reset
        end else begin
            if (accept) begin
                // unchanged by default, the arms below override
                x_pend    <= x_start;
                y_pend    <= y_start;
                step_pend <= step;
                if (sig_up || sig_dn) changed <= 1'b1;

                case (mode)
                    MODE_HORIZONTAL: begin
                        if (sig_up) x_pend <= x_start - pan;       // left
                        else if (sig_dn) x_pend <= x_start + pan;  // right
                        if (sig_mode) mode <= MODE_VERTICAL;
                    end
                    MODE_VERTICAL: begin
                        if (sig_up) y_pend <= y_start - pan;
                        else if (sig_dn) y_pend <= y_start + pan;
                        if (sig_mode) mode <= MODE_ZOOM;
                    end
                    MODE_ZOOM: begin
                        if (sig_up) begin  // zoom out about the centre
                            x_pend    <= x_start - (step <<< 3);
                            y_pend    <= y_start - (step <<< 2);
                            step_pend <= step <<< 1;
                        end else if (sig_dn) begin  // zoom in
                            x_pend    <= x_start + (step <<< 2);
                            y_pend    <= y_start + (step <<< 1);
                            step_pend <= step >>> 1;
                        end
                        if (sig_mode) mode <= MODE_HORIZONTAL;
                    end
                    default: mode <= MODE_HORIZONTAL;  // unused encoding
                endcase
            end

            // check one cycle after the proposal, then render
            if (changed && !busy) begin
                changed <= 1'b0;
                if (step_pend != '0 && step_pend <= STEP_MAX) begin
                    x_start    <= x_pend;
                    y_start    <= y_pend;
                    step       <= step_pend;
                    render_req <= 1'b1;
                end  // out of range: proposal dropped
            end else if (render_req && !busy) begin
                start      <= 1'b1;
                render_req <= 1'b0;
            end
        end
    end

    // a zero pitch would render one point 128 times
    a_step_nonzero: assert property (@(posedge clk_sys) disable iff (rst_sys)
        step != '0)
        else $error("nav_fsm: view step is zero");

    // scanner must never see start during a render
    a_start_idle: assert property (@(posedge clk_sys) disable iff (rst_sys)
        start |-> !busy)
        else $error("nav_fsm: start while busy");

endmodule

//--- rtl/pixel_job_if.sv
// one pixel job, at most one open at a time
// c_re and c_im held from req until done, cidx valid only with done
`timescale 1ns/1ps

interface pixel_job_if;
    import mandel_fp_pkg::*;

    logic  req;    // job start pulse
    fp_t   c_re;   // point to test
    fp_t   c_im;
    logic  done;   // result pulse
    cidx_t cidx;   // escape index, 0 = inside

    modport scan (output req, c_re, c_im, input done, cidx);
    modport engine (input req, c_re, c_im, output done, cidx);

endinterface

//--- rtl/pixel_scan.sv
// view is latched on start so later view changes do not reach a running frame
// start while busy is ignored so only one frame runs at a time
`timescale 1ns/1ps

module pixel_scan (
    input  logic                      clk_sys,
    input  logic                      rst_sys,
    input  logic                      start,
    input  mandel_fp_pkg::fp_t        x_start,
    input  mandel_fp_pkg::fp_t        y_start,
    input  mandel_fp_pkg::fp_t        step,
    output logic                      busy,
    pixel_job_if.scan                 job,
    output logic                      we,       // frame store write
    output mandel_view_pkg::fb_addr_t wr_addr,
    output mandel_fp_pkg::cidx_t      wr_cidx
);
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;

    localparam int COL_W = $clog2(FB_W);
    localparam int ROW_W = $clog2(FB_H);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_WRITE} state_t;

    state_t           state;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    fp_t              x_left;    // latched left edge for row wrap
    fp_t              step_q;    // latched pitch
    fp_t              c_re;      // current point
    fp_t              c_im;
    logic             job_open;  // req sent and done not yet seen
    logic             last_pix;

    assign busy     = (state != S_IDLE);
    assign job.req  = (state == S_REQ);   // single cycle since S_REQ always moves on
    assign job.c_re = c_re;
    assign job.c_im = c_im;
    assign we       = (state == S_WRITE);  // one cycle after done
    assign wr_addr  = fb_addr_t'(int'(row) * FB_W + int'(col));
    assign last_pix = (int'(col) == FB_W - 1) && (int'(row) == FB_H - 1);

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= S_IDLE;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                S_IDLE: if (start) begin
                    x_left <= x_start;
                    step_q <= step;
                    c_re   <= x_start;
                    c_im   <= y_start;
                    col    <= '0;
                    row    <= '0;
                    state  <= S_REQ;
                end
                S_REQ: state <= S_WAIT;
                S_WAIT: if (job.done) begin
                    wr_cidx <= job.cidx;
                    state   <= S_WRITE;
                end
                S_WRITE: begin
                    if (last_pix) begin
                        state <= S_IDLE;  // busy drops next cycle
                    end else begin
                        state <= S_REQ;
                        if (int'(col) == FB_W - 1) begin  // next row
                            col  <= '0;
                            row  <= row + 1'b1;
                            c_re <= x_left;
                            c_im <= c_im + step_q;
                        end else begin
                            col  <= col + 1'b1;
                            c_re <= c_re + step_q;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // outstanding job tracker closed by the engine's done
    always_ff @(posedge clk_sys) begin
        if (rst_sys) job_open <= 1'b0;
        else if (job.req) job_open <= 1'b1;
        else if (job.done) job_open <= 1'b0;
    end

    // the engine answers only the job that is open
    a_done_open: assert property (@(posedge clk_sys) disable iff (rst_sys)
        job.done |-> job_open)
        else $error("pixel_scan: done without an open job");

endmodule
